// File: src/qdr_out_macros.svh
// **********************************************************************
// build-time settings for the QDR II write-data output path
// include wherever the beat width, reset level or register map is needed
// **********************************************************************
`ifndef QDR_OUT_MACROS_SVH
`define QDR_OUT_MACROS_SVH

// width of one data beat on the pin bus
`define QDR_BEAT_W 18

// 1 makes every data register come out of reset as all ones
`define QDR_POST_RESET_HIGH 0

// 1 adds the falling-edge register on the second beat (3-register form)
`define QDR_EXTRA_NEG_REG 1

// configuration register map
`define QDR_ADDR_CTRL  2'd0
`define QDR_ADDR_IDLE  2'd1
`define QDR_ADDR_COUNT 2'd2

`endif

// File: src/qdr_out_pkg.sv
// **********************************************************************
// shared types for the write-data output path
// modules pull these in with a wildcard import in their header
// **********************************************************************
`default_nettype none

`include "qdr_out_macros.svh"

package qdr_out_pkg;

	// full half-rate word width, two beats
	localparam int HR_W = 2 * `QDR_BEAT_W;

	// level every data register takes while in reset
	localparam logic QDR_RST_LEVEL = (`QDR_POST_RESET_HIGH != 0);

	// one half-rate word
	// flat view for storing and comparing the word whole
	// beat view for steering each beat to its own clock phase
	// beat[0] goes out first, in the high phase of clk
	typedef union packed {
		logic [HR_W-1:0]                 flat;
		logic [1:0][`QDR_BEAT_W-1:0]     beat;
	} hr_word_t;

	// post-reset content of a data word
	localparam hr_word_t HR_RST_WORD = {HR_W{QDR_RST_LEVEL}};

	// configuration register address
	typedef logic [1:0] reg_addr_t;

endpackage

`default_nettype wire

// File: src/qdr_out_regs.sv
// **********************************************************************
// configuration and status registers beside the write formatter
// sets the output enable and idle pattern, counts the words sent
// **********************************************************************
`timescale 1ns/100ps
`default_nettype none

`include "qdr_out_macros.svh"

module qdr_out_regs
	import qdr_out_pkg::*;
(
	input  logic        clk,
	input  logic        dr_reset_n,
	input  logic        cfg_wr,
	input  reg_addr_t   cfg_addr,
	input  logic [31:0] cfg_wdata,
	output logic [31:0] cfg_rdata,
	input  logic        word_sent,
	output logic        out_enable,
	output hr_word_t    idle_pattern
);

	// words sent so far, wraps at 2^32
	logic [31:0] sent_count;

	// **********************************************************************
	// write decode
	// **********************************************************************

	// writes land at the edge that samples cfg_wr
	// address 2 is read-only so a write there falls through the default
	always_ff @(posedge clk or negedge dr_reset_n) begin
		if (!dr_reset_n) begin
			out_enable   <= 1'b0;
			idle_pattern <= '0;
		end else if (cfg_wr) begin
			case (cfg_addr)
				`QDR_ADDR_CTRL: begin
					out_enable <= cfg_wdata[0];
				end
				`QDR_ADDR_IDLE: begin
					// zero-extended to the word, upper beat bits stay 0
					idle_pattern.flat <= HR_W'(cfg_wdata);
				end
				default: begin
				end
			endcase
		end
	end

	// **********************************************************************
	// sent-word counter
	// **********************************************************************

	// word_sent is a one-cycle pulse from the formatter
	// count moves one cycle after the pulse
	always_ff @(posedge clk or negedge dr_reset_n) begin
		if (!dr_reset_n) begin
			sent_count <= '0;
		end else if (word_sent) begin
			sent_count <= sent_count + 32'd1;
		end
	end

	// **********************************************************************
	// read mux, purely combinational on cfg_addr
	// **********************************************************************
	always_comb begin
		case (cfg_addr)
			`QDR_ADDR_CTRL:  cfg_rdata = {31'd0, out_enable};
			// only the low 32 bits of the idle word are visible
			`QDR_ADDR_IDLE:  cfg_rdata = 32'(idle_pattern.flat);
			`QDR_ADDR_COUNT: cfg_rdata = sent_count;
			default:         cfg_rdata = 32'd0;
		endcase
	end

endmodule

`default_nettype wire

// File: src/qdr_wr_formatter.sv
// **********************************************************************
// write-word formatter ahead of the DDR output stage
// picks write data or the idle pattern each cycle and flags sent words
// **********************************************************************
`timescale 1ns/100ps
`default_nettype none

`include "qdr_out_macros.svh"

module qdr_wr_formatter
	import qdr_out_pkg::*;
(
	input  logic     clk,
	input  logic     dr_reset_n,
	input  logic     wr_valid,
	input  hr_word_t wr_data,
	input  logic     out_enable,
	input  hr_word_t idle_pattern,
	output hr_word_t fmt_word,
	output logic     fmt_oe,
	output logic     word_sent
);

	// word chosen for the coming cycle
	hr_word_t next_word;
	// a write word is taken this cycle
	logic     take_wr;

	// **********************************************************************
	// word select
	// **********************************************************************

	// a write word is only taken while the path is enabled
	// with no back-pressure every cycle still yields one word
	assign take_wr = out_enable & wr_valid;

	// disabled or no valid data, so the idle word fills the slot
	always_comb begin
		if (take_wr) begin
			next_word = wr_data;
		end else begin
			next_word = idle_pattern;
		end
	end

	// **********************************************************************
	// output word register
	// **********************************************************************

	// word sampled at edge k is on fmt_word for the cycle after k
	// comes out of reset at the same level as the DDR registers
	always_ff @(posedge clk or negedge dr_reset_n) begin
		if (!dr_reset_n) begin
			fmt_word <= HR_RST_WORD;
		end else begin
			fmt_word <= next_word;
		end
	end

	// **********************************************************************
	// drive enable and sent strobe
	// **********************************************************************

	// pins are driven whenever enabled, idle cycles included
	// word_sent feeds the counter in the register block
	always_ff @(posedge clk or negedge dr_reset_n) begin
		if (!dr_reset_n) begin
			fmt_oe    <= 1'b0;
			word_sent <= 1'b0;
		end else begin
			fmt_oe    <= out_enable;
			// pulse lines up with the word it counts
			word_sent <= take_wr;
		end
	end

endmodule

`default_nettype wire

// File: src/ddio_out_stage.sv
// **********************************************************************
// soft-logic DDR output, one half-rate word becomes two pin beats
// beat[0] is driven while clk is high, beat[1] while clk is low
// **********************************************************************
`timescale 1ns/100ps
`default_nettype none

`include "qdr_out_macros.svh"

module ddio_out_stage
	import qdr_out_pkg::*;
(
	input  logic                   clk,
	input  logic                   dr_reset_n,
	input  hr_word_t               fmt_word,
	input  logic                   fmt_oe,
	output logic [`QDR_BEAT_W-1:0] dq,
	output logic                   dq_oe
);

	localparam int W         = `QDR_BEAT_W;
	localparam bit EXTRA_NEG = (`QDR_EXTRA_NEG_REG != 0);

	// rising-edge input register
	hr_word_t     word_r;
	// source for the high phase
	logic [W-1:0] beat_hi;
	// source for the low phase
	logic [W-1:0] beat_lo;

	// **********************************************************************
	// rising-edge capture
	// **********************************************************************

	// word and enable move together at edge k+1
	always_ff @(posedge clk or negedge dr_reset_n) begin
		if (!dr_reset_n) begin
			word_r <= HR_RST_WORD;
			dq_oe  <= 1'b0;
		end else begin
			word_r <= fmt_word;
			dq_oe  <= fmt_oe;
		end
	end

	assign beat_hi = word_r.beat[0];

	// **********************************************************************
	// optional falling-edge register for the second beat
	// **********************************************************************

	// word_r has been stable since the rising edge
	// so the falling-edge copy holds the same beat[1] and timing is kept
	generate
		if (EXTRA_NEG) begin : g_neg_reg
			logic [W-1:0] beat1_n;

			always_ff @(negedge clk or negedge dr_reset_n) begin
				if (!dr_reset_n) begin
					beat1_n <= {W{QDR_RST_LEVEL}};
				end else begin
					beat1_n <= word_r.beat[1];
				end
			end

			assign beat_lo = beat1_n;
		end else begin : g_no_neg_reg
			// two-register form, low phase straight from the input register
			assign beat_lo = word_r.beat[1];
		end
	endgenerate

	// **********************************************************************
	// phase mux
	// **********************************************************************

	// clk itself selects the beat
	assign dq = clk ? beat_hi : beat_lo;

endmodule

`default_nettype wire

// File: src/qdr_wr_out_path.sv
// **********************************************************************
// top of the QDR II write-data output path
// register block and formatter feed the DDR output stage on one clock
// **********************************************************************
`timescale 1ns/100ps
`default_nettype none

`include "qdr_out_macros.svh"

module qdr_wr_out_path
	import qdr_out_pkg::*;
(
	input  logic                   clk,
	input  logic                   dr_reset_n,
	input  logic                   wr_valid,
	input  hr_word_t               wr_data,
	input  logic                   cfg_wr,
	input  reg_addr_t              cfg_addr,
	input  logic [31:0]            cfg_wdata,
	output logic [31:0]            cfg_rdata,
	output logic [`QDR_BEAT_W-1:0] dq,
	output logic                   dq_oe
);

	// register block to formatter
	logic     out_enable;
	hr_word_t idle_pattern;
	// formatter back to the counter
	logic     word_sent;
	// formatter to DDR stage
	hr_word_t fmt_word;
	logic     fmt_oe;

	qdr_out_regs u_qdr_out_regs (
		.clk          (clk),
		.dr_reset_n   (dr_reset_n),
		.cfg_wr       (cfg_wr),
		.cfg_addr     (cfg_addr),
		.cfg_wdata    (cfg_wdata),
		.cfg_rdata    (cfg_rdata),
		.word_sent    (word_sent),
		.out_enable   (out_enable),
		.idle_pattern (idle_pattern)
	);

	// one cycle of latency here
	qdr_wr_formatter u_qdr_wr_formatter (
		.clk          (clk),
		.dr_reset_n   (dr_reset_n),
		.wr_valid     (wr_valid),
		.wr_data      (wr_data),
		.out_enable   (out_enable),
		.idle_pattern (idle_pattern),
		.fmt_word     (fmt_word),
		.fmt_oe       (fmt_oe),
		.word_sent    (word_sent)
	);

	// and one more before the beats reach the pins
	ddio_out_stage u_ddio_out_stage (
		.clk        (clk),
		.dr_reset_n (dr_reset_n),
		.fmt_word   (fmt_word),
		.fmt_oe     (fmt_oe),
		.dq         (dq),
		.dq_oe      (dq_oe)
	);

endmodule

`default_nettype wire

// File: tests/qdr_wr_out_path_sva.sv
// **********************************************************************
// concurrent checks on the DDR pins and drive enable of the write path
// bound to the top level, failed checks are tallied in fail_count
// **********************************************************************
`timescale 1ns/100ps
`default_nettype none

`include "qdr_out_macros.svh"

module qdr_wr_out_path_sva
	import qdr_out_pkg::*;
(
	input logic                   clk,
	input logic                   dr_reset_n,
	input logic                   wr_valid,
	input hr_word_t               wr_data,
	input logic                   cfg_wr,
	input reg_addr_t              cfg_addr,
	input logic [31:0]            cfg_wdata,
	input logic [`QDR_BEAT_W-1:0] dq,
	input logic                   dq_oe
);

	localparam int   W       = `QDR_BEAT_W;
	localparam logic RST_BIT = (`QDR_POST_RESET_HIGH != 0);

	// read by the testbench at the end of the run
	int unsigned fail_count = 0;

	// reference view of the register block
	logic     en_m;
	hr_word_t idle_m;
	// word and enable the path should take at this edge
	hr_word_t exp_word;
	// two-stage history, h2 is the word now on the pins
	hr_word_t word_h1;
	hr_word_t word_h2;
	logic     oe_h1;
	logic     oe_h2;

	// **********************************************************************
	// reference model
	// **********************************************************************

	// writes land at the sampling edge, address 2 is read-only
	always_ff @(posedge clk or negedge dr_reset_n) begin
		if (!dr_reset_n) begin
			en_m        <= 1'b0;
			idle_m.flat <= '0;
		end else if (cfg_wr && cfg_addr == `QDR_ADDR_CTRL) begin
			en_m <= cfg_wdata[0];
		end else if (cfg_wr && cfg_addr == `QDR_ADDR_IDLE) begin
			idle_m.flat <= HR_W'(cfg_wdata);
		end
	end

	// idle word fills every slot without an accepted write
	assign exp_word = (en_m && wr_valid) ? wr_data : idle_m;

	always_ff @(posedge clk or negedge dr_reset_n) begin
		if (!dr_reset_n) begin
			word_h1.flat <= {HR_W{RST_BIT}};
			word_h2.flat <= {HR_W{RST_BIT}};
			oe_h1        <= 1'b0;
			oe_h2        <= 1'b0;
		end else begin
			word_h1 <= exp_word;
			word_h2 <= word_h1;
			oe_h1   <= en_m;
			oe_h2   <= oe_h1;
		end
	end

	// **********************************************************************
	// pin checks
	// **********************************************************************

	// pins sit at the post-reset level and are not driven
	a_reset_level: assert property (@(negedge clk)
		!dr_reset_n |-> (!dq_oe && dq == {W{RST_BIT}}))
		else begin
			fail_count = fail_count + 1;
			$error("MISMATCH a_reset_level: expected dq 0x%h oe 0, actual dq 0x%h oe %0b",
				{W{RST_BIT}}, $sampled(dq), $sampled(dq_oe));
		end

	// high phase carries the first beat
	a_first_beat: assert property (@(negedge clk) disable iff (!dr_reset_n)
		dq == word_h2.beat[0])
		else begin
			fail_count = fail_count + 1;
			$error("MISMATCH a_first_beat: expected 0x%h, actual 0x%h",
				$sampled(word_h2.beat[0]), $sampled(dq));
		end

	// low phase carries the second beat, enable moves with the word
	a_second_beat: assert property (@(posedge clk) disable iff (!dr_reset_n)
		(dq == word_h2.beat[1] && dq_oe == oe_h2))
		else begin
			fail_count = fail_count + 1;
			$error("MISMATCH a_second_beat: expected dq 0x%h oe %0b, actual dq 0x%h oe %0b",
				$sampled(word_h2.beat[1]), $sampled(oe_h2), $sampled(dq), $sampled(dq_oe));
		end

	// enabled cycle with no data still drives, with the idle beats
	// the model word two edges back is that idle word
	a_idle_fill: assert property (@(posedge clk) disable iff (!dr_reset_n)
		$past(en_m && !wr_valid, 2) |-> (dq_oe && dq == $past(idle_m.beat[1], 2)))
		else begin
			fail_count = fail_count + 1;
			$error("MISMATCH a_idle_fill: expected dq 0x%h oe 1, actual dq 0x%h oe %0b",
				$sampled(word_h2.beat[1]), $sampled(dq), $sampled(dq_oe));
		end

	// clearing the enable releases the pins on the third edge
	a_disable: assert property (@(posedge clk) disable iff (!dr_reset_n)
		$past(cfg_wr && cfg_addr == `QDR_ADDR_CTRL && !cfg_wdata[0], 3)
		|-> (!dq_oe && dq == $past(idle_m.beat[1], 2)))
		else begin
			fail_count = fail_count + 1;
			$error("MISMATCH a_disable: expected dq 0x%h oe 0, actual dq 0x%h oe %0b",
				$sampled(word_h2.beat[1]), $sampled(dq), $sampled(dq_oe));
		end

endmodule

bind qdr_wr_out_path qdr_wr_out_path_sva u_qdr_wr_out_path_sva (
	.clk        (clk),
	.dr_reset_n (dr_reset_n),
	.wr_valid   (wr_valid),
	.wr_data    (wr_data),
	.cfg_wr     (cfg_wr),
	.cfg_addr   (cfg_addr),
	.cfg_wdata  (cfg_wdata),
	.dq         (dq),
	.dq_oe      (dq_oe)
);

`default_nettype wire

// File: tests/qdr_wr_out_path_tb.sv
// **********************************************************************
// testbench for the QDR II write-data output path
// random write traffic and register accesses, pin checks come from the bound SVA
// **********************************************************************
`timescale 1ns/100ps
`default_nettype none

`include "qdr_out_macros.svh"

module qdr_wr_out_path_tb
	import qdr_out_pkg::*;
();

	localparam int TIMEOUT_NS = 100000;

	logic                   clk;
	logic                   dr_reset_n;
	logic                   wr_valid;
	hr_word_t               wr_data;
	logic                   cfg_wr;
	reg_addr_t              cfg_addr;
	logic [31:0]            cfg_wdata;
	logic [31:0]            cfg_rdata;
	logic [`QDR_BEAT_W-1:0] dq;
	logic                   dq_oe;

	// reference state kept alongside the stimulus
	logic        en_model;
	logic [31:0] model_count;
	int          reg_errors;

	qdr_wr_out_path u_qdr_wr_out_path (
		.clk        (clk),
		.dr_reset_n (dr_reset_n),
		.wr_valid   (wr_valid),
		.wr_data    (wr_data),
		.cfg_wr     (cfg_wr),
		.cfg_addr   (cfg_addr),
		.cfg_wdata  (cfg_wdata),
		.cfg_rdata  (cfg_rdata),
		.dq         (dq),
		.dq_oe      (dq_oe)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// hard stop in case the sequence never reaches its end
	initial begin
		#(TIMEOUT_NS);
		$display("timeout: the test sequence did not finish in time");
		$display("Simulation FAILED");
		$finish;
	end

	// **********************************************************************
	// stimulus tasks
	// **********************************************************************

	// one cycle of inputs, set on the falling edge
	// random data goes out even when not valid, it must be ignored
	task automatic drive_cycle(input logic valid, input logic wr, input reg_addr_t addr,
		input logic [31:0] wdata);
		logic [63:0] rnd;
		rnd = {$urandom(), $urandom()};
		@(negedge clk);
		wr_valid     = valid;
		wr_data.flat = rnd[HR_W-1:0];
		cfg_wr       = wr;
		cfg_addr     = addr;
		cfg_wdata    = wdata;
		// the word sees the enable from before this cycle's write
		if (valid && en_model) begin
			model_count = model_count + 32'd1;
		end
		if (wr && addr == `QDR_ADDR_CTRL) begin
			en_model = wdata[0];
		end
	endtask

	task automatic write_reg(input reg_addr_t addr, input logic [31:0] wdata);
		drive_cycle(1'b0, 1'b1, addr, wdata);
	endtask

	// about three valid words in four cycles
	task automatic random_traffic(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			drive_cycle($urandom_range(3, 0) != 0, 1'b0, `QDR_ADDR_CTRL, 32'd0);
		end
	endtask

	task automatic read_check(input string name, input reg_addr_t addr,
		input logic [31:0] expected);
		@(negedge clk);
		wr_valid = 1'b0;
		cfg_wr   = 1'b0;
		cfg_addr = addr;
		// read path is combinational, look away from the clock edges
		#1;
		if (cfg_rdata !== expected) begin
			reg_errors++;
			$display("MISMATCH %s: expected 0x%08h, actual 0x%08h", name, expected, cfg_rdata);
		end
	endtask

	// counter trails the last accepted word by two cycles
	task automatic wait_count(input logic [31:0] expected, input int limit);
		int  tries;
		logic done;
		tries = 0;
		done  = 1'b0;
		while (!done && tries < limit) begin
			@(negedge clk);
			wr_valid = 1'b0;
			cfg_wr   = 1'b0;
			cfg_addr = `QDR_ADDR_COUNT;
			#1;
			done  = (cfg_rdata == expected);
			tries = tries + 1;
		end
		if (!done) begin
			reg_errors++;
			$display("MISMATCH sent count: expected 0x%08h, actual 0x%08h", expected, cfg_rdata);
		end
	endtask

	// **********************************************************************
	// test sequence
	// **********************************************************************
	initial begin : main_seq
		logic [31:0] idle_a;
		logic [31:0] idle_b;
		int unsigned sva_fails;
		void'($urandom(32'h79aee651));
		dr_reset_n   = 1'b1;
		wr_valid     = 1'b0;
		wr_data.flat = '0;
		cfg_wr       = 1'b0;
		cfg_addr     = `QDR_ADDR_CTRL;
		cfg_wdata    = 32'd0;
		en_model     = 1'b0;
		model_count  = 32'd0;
		reg_errors   = 0;
		#1 dr_reset_n = 1'b0;
		repeat (5) @(negedge clk);
		dr_reset_n = 1'b1;

		// quiet pins before any write
		random_traffic(4);
		read_check("ctrl after reset", `QDR_ADDR_CTRL, 32'd0);
		read_check("idle after reset", `QDR_ADDR_IDLE, 32'd0);
		read_check("count after reset", `QDR_ADDR_COUNT, 32'd0);

		idle_a = $urandom();
		write_reg(`QDR_ADDR_IDLE, idle_a);
		write_reg(`QDR_ADDR_CTRL, 32'd1);
		random_traffic(120);
		// swap the idle word mid-stream
		idle_b = $urandom();
		write_reg(`QDR_ADDR_IDLE, idle_b);
		random_traffic(80);

		// clear the enable, later words are not counted
		write_reg(`QDR_ADDR_CTRL, 32'd0);
		random_traffic(8);
		wait_count(model_count, 10);

		read_check("ctrl after disable", `QDR_ADDR_CTRL, 32'd0);
		read_check("idle pattern", `QDR_ADDR_IDLE, idle_b);
		write_reg(`QDR_ADDR_COUNT, 32'hdead_beef);
		read_check("count after write to address 2", `QDR_ADDR_COUNT, model_count);
		write_reg(`QDR_ADDR_CTRL, 32'd1);
		read_check("ctrl after enable", `QDR_ADDR_CTRL, 32'd1);
		write_reg(`QDR_ADDR_CTRL, 32'd0);

		// let the last assertions fire
		random_traffic(6);
		sva_fails = u_qdr_wr_out_path.u_qdr_wr_out_path_sva.fail_count;
		$display("check summary: %0d register mismatches, %0d assertion failures",
			reg_errors, sva_fails);
		if (reg_errors == 0 && sva_fails == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+src
src/qdr_out_pkg.sv
src/qdr_out_regs.sv
src/qdr_wr_formatter.sv
src/ddio_out_stage.sv
src/qdr_wr_out_path.sv
tests/qdr_wr_out_path_sva.sv
tests/qdr_wr_out_path_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the write-path testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f \
	--top-module qdr_wr_out_path_tb -Mdir obj_dir \
	|| { echo "build failed"; exit 1; }

result=$(./obj_dir/Vqdr_wr_out_path_tb +verilator+error+limit+1000 2>&1)
echo "$result"
echo "$result" | grep -q "^Simulation PASSED$" && exit 0 || exit 1
